// File: Makefile
# Verilator build and run for the microstepper testbench

VERILATOR ?= verilator
TOP       ?= microstepper_tb
FILELIST  ?= microstepper.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/microstepper_checker.sv
`timescale 1ns/1ps
`default_nettype none

module microstepper_checker
  import bridge_pkg::*;
(
  input logic         clk,
  input logic         resetn,
  input gate_t        gate_h,
  input gate_t        gate_l,
  input off_timer_t   off_timer,
  input blank_timer_t blank_timer
);

  int assert_fails = 0;  // Read by the testbench at the end of the run

  // A leg with its high side on (h=0) and its low side on (l=1) shorts the supply
  no_shoot_through: assert property (@(posedge clk) disable iff (!resetn)
    (~gate_h & gate_l) == 2'b00)
    else begin
      $error("shoot-through on a bridge leg");
      assert_fails = assert_fails + 1;
    end

  // A running off period only counts down, so a reload can only start from zero
  load_from_zero: assert property (@(posedge clk) disable iff (!resetn)
    (off_timer != '0) |=> (off_timer == $past(off_timer) - off_timer_t'(1)))
    else begin
      $error("off timer reloaded before reaching zero");
      assert_fails = assert_fails + 1;
    end

  no_load_in_blank: assert property (@(posedge clk) disable iff (!resetn)
    (off_timer == '0 && blank_timer != '0) |=> (off_timer == '0))
    else begin
      $error("off timer loaded inside the blanking window");
      assert_fails = assert_fails + 1;
    end

endmodule

bind coil_chopper microstepper_checker chk_i (
  .clk         (clk),
  .resetn      (resetn),
  .gate_h      (gate_h),
  .gate_l      (gate_l),
  .off_timer   (off_timer),
  .blank_timer (blank_timer)
);

`default_nettype wire

// File: bench/microstepper_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module microstepper_tb
  import stepper_pkg::*, bridge_pkg::*;
();

  localparam int NUM_BURSTS     = 12;
  localparam int MAX_BURST      = 8;
  localparam int PULSE_CYCLES   = 270;
  localparam int TIMEOUT_CYCLES = 40 + NUM_BURSTS * MAX_BURST * PULSE_CYCLES
                                + 2 * (`OFF_TIME + 200) + 256 * 6 + 100
                                + 24 * `CP_HALF_PERIOD + 1000;

  logic       clk = 1'b0;
  logic       resetn, step, dir, enable, cmp_a, cmp_b;
  logic [3:0] s_h, s_l;
  logic       ref_a, ref_b, chargepump_pin;

  int          errors = 0;
  int          test_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] lfsr = 32'h59c6;
  phase_t      phase_model = '0;  // Phase the bench expects the DUT to hold

  microstepper_top dut_i (
    .clk (clk), .resetn (resetn), .step (step), .dir (dir), .enable (enable),
    .cmp_a (cmp_a), .cmp_b (cmp_b), .s_h (s_h), .s_l (s_l),
    .ref_a (ref_a), .ref_b (ref_b), .chargepump_pin (chargepump_pin)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ==================================================================
  // Helpers and reference model
  // ==================================================================

  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic real coil_cos(input phase_t p);
    return $cos((real'(p) + 0.5) * 3.14159265358979 / 128.0);
  endfunction

  function automatic magnitude_t expected_mag(input phase_t p);
    real c;
    c = 255.0 * coil_cos(p);
    if (c < 0.0) c = -c;
    return magnitude_t'($rtoi(c + 0.5));
  endfunction

  function automatic logic expected_pol(input phase_t p);
    return coil_cos(p) > 0.0;
  endfunction

  // The drive pattern is the same on h and l and polarity 1 pulls leg 2 low
  function automatic gate_t drive_pattern(input logic pol);
    return pol ? 2'b10 : 2'b01;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic check_gates(input string name, input gate_t got, input gate_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_magnitude(input string name, input magnitude_t got,
                                 input magnitude_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_drive;
    gate_t pa;
    gate_t pb;
    pa = drive_pattern(expected_pol(phase_model));
    pb = drive_pattern(expected_pol(phase_model + phase_t'(64)));
    check_gates("s_h[1:0]", s_h[1:0], pa);
    check_gates("s_l[1:0]", s_l[1:0], pa);
    check_gates("s_h[3:2]", s_h[3:2], pb);
    check_gates("s_l[3:2]", s_l[3:2], pb);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors > test_start) begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, errors - test_start);
    end else begin
      $display("%s: ok", name);
    end
    test_start = errors;
  endtask

  task automatic pulse_step(input logic d);
    step = 1'b1;
    dir  = d;
    next_cycles(2);
    step = 1'b0;
    next_cycles(2);
    phase_model = d ? phase_model + phase_t'(1) : phase_model - phase_t'(1);
  endtask

  // ==================================================================
  // Tests
  // ==================================================================

  task automatic test_reset_enable;
    check_gates("s_h[1:0]", s_h[1:0], 2'b11);
    check_gates("s_h[3:2]", s_h[3:2], 2'b11);
    check_gates("s_l[1:0]", s_l[1:0], 2'b00);
    check_gates("s_l[3:2]", s_l[3:2], 2'b00);
    enable = 1'b1;
    next_cycles(2);
    check_drive();
    finish_test("reset_enable");
  endtask

  task automatic test_random_steps;
    int count;
    int d;
    int high_a;
    int high_b;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      random_bits(3, count);
      for (int k = 0; k <= count; k++) begin
        random_bits(1, d);
        pulse_step(d[0]);
        next_cycles(2);
        high_a = 0;
        high_b = 0;
        repeat (256) begin
          high_a += int'(ref_a);
          high_b += int'(ref_b);
          next_cycles(1);
        end
        check_magnitude("ref_a high count", magnitude_t'(high_a), expected_mag(phase_model));
        check_magnitude("ref_b high count", magnitude_t'(high_b),
                        expected_mag(phase_model + phase_t'(64)));
        check_drive();
      end
    end
    finish_test("random_steps");
  endtask

  task automatic test_chopping;
    gate_t drv;
    int    fast;
    int    slow;
    int    n;
    drv  = drive_pattern(expected_pol(phase_model));
    fast = 0;
    slow = 0;
    next_cycles(40);  // Let any blanking window run out
    cmp_a = 1'b1;
    next_cycles(2);
    cmp_a = 1'b0;
    for (n = 0; n < `OFF_TIME + 100; n++) begin
      if (s_h[1:0] == ~drv && s_l[1:0] == ~drv) fast++;
      else if (s_h[1:0] == 2'b11 && s_l[1:0] == 2'b11) slow++;
      else if (s_h[1:0] == drv && s_l[1:0] == drv) break;
      else report_error("coil A gates show a pattern outside drive and decay");
      check_gates("s_h[3:2]", s_h[3:2], drive_pattern(expected_pol(phase_model + 8'd64)));
      next_cycles(1);
    end
    if (fast < 104 || fast > 106)
      report_error($sformatf("fast decay lasted %0d cycles instead of 105", fast));
    if (fast + slow < `OFF_TIME - 1 || fast + slow > `OFF_TIME + 1)
      report_error($sformatf("off period lasted %0d cycles", fast + slow));
    finish_test("chopping");
  endtask

  task automatic test_blanking;
    logic flipped;
    int   n;
    while (phase_model != phase_t'(63)) pulse_step(1'b1);
    next_cycles(40);
    step    = 1'b1;
    dir     = 1'b1;
    flipped = 1'b0;
    for (int i = 0; i < 20 && !flipped; i++) begin
      next_cycles(1);
      if (i == 1) step = 1'b0;
      flipped = s_h[1:0] == drive_pattern(1'b0);
    end
    step = 1'b0;
    phase_model = phase_model + phase_t'(1);
    if (!flipped) report_error("coil A polarity did not flip at the quadrant boundary");
    cmp_a = 1'b1;
    n = 0;
    while (n < 100) begin
      next_cycles(1);
      n++;
      if (s_h[1:0] == drive_pattern(1'b1) && s_l[1:0] == drive_pattern(1'b1)) break;
      check_gates("s_h[1:0] blanked", s_h[1:0], drive_pattern(1'b0));
      check_gates("s_l[1:0] blanked", s_l[1:0], drive_pattern(1'b0));
    end
    cmp_a = 1'b0;
    if (n < `BLANK_TIME || n > `BLANK_TIME + 3)
      report_error($sformatf("fast decay began %0d cycles after the flip", n));
    n = 0;
    while (n < `OFF_TIME + 50 && s_l[1:0] != drive_pattern(1'b0)) begin
      next_cycles(1);
      n++;
    end
    check_drive();
    finish_test("blanking");
  endtask

  task automatic test_charge_pump;
    logic prev;
    int   n;
    prev = chargepump_pin;
    n = 0;
    while (chargepump_pin == prev && n < 2 * `CP_HALF_PERIOD + 4) begin
      next_cycles(1);
      n++;
    end
    for (int t = 0; t < 20; t++) begin
      prev = chargepump_pin;
      n = 0;
      while (chargepump_pin == prev && n < 2 * `CP_HALF_PERIOD) begin
        next_cycles(1);
        n++;
      end
      if (n != `CP_HALF_PERIOD)
        report_error($sformatf("charge pump half period was %0d cycles", n));
    end
    finish_test("charge_pump");
  endtask

  initial begin
    resetn = 1'b0;
    step   = 1'b0;
    dir    = 1'b0;
    enable = 1'b0;
    cmp_a  = 1'b0;
    cmp_b  = 1'b0;
    repeat (10) @(posedge clk);
    #1 resetn = 1'b1;
    next_cycles(2);
    test_reset_enable();
    test_random_steps();
    test_chopping();
    test_blanking();
    test_charge_pump();
    errors += dut_i.chop_a.chk_i.assert_fails + dut_i.chop_b.chk_i.assert_fails;
    $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: microstepper.f
+incdir+rtl
rtl/stepper_pkg.sv
rtl/bridge_pkg.sv
rtl/step_sequencer.sv
rtl/cosine_table.sv
rtl/current_reference_dac.sv
rtl/coil_chopper.sv
rtl/charge_pump.sv
rtl/microstepper_top.sv
bench/microstepper_checker.sv
bench/microstepper_tb.sv

// File: rtl/bridge_pkg.sv
`default_nettype none

`include "microstepper_macros.svh"

package bridge_pkg;

  // One bit per bridge leg with leg 1 in bit 0
  typedef logic [1:0] gate_t;

  typedef logic [`OFF_TIMER_W-1:0]             off_timer_t;
  typedef logic [`BLANK_TIMER_W-1:0]           blank_timer_t;
  typedef logic [$clog2(`CP_HALF_PERIOD)-1:0]  cp_count_t;

  typedef enum logic [1:0] {
    drive,
    fast_decay,
    slow_decay,
    coast
  } decay_t;

endpackage

`default_nettype wire

// File: rtl/charge_pump.sv
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module charge_pump
  import bridge_pkg::*;
(
  input  logic clk,
  input  logic resetn,
  output logic pump
);

  cp_count_t div_count;

  // Square wave for the high-side bootstrap supply
  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_count <= '0;
      pump      <= 1'b0;
    end else if (div_count == cp_count_t'(`CP_HALF_PERIOD - 1)) begin
      div_count <= '0;
      pump      <= ~pump;
    end else begin
      div_count <= div_count + cp_count_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: rtl/coil_chopper.sv
`timescale 1ns/1ps
`default_nettype none

`include "microstepper_macros.svh"

module coil_chopper
  import bridge_pkg::*;
(
  input  logic  clk,
  input  logic  resetn,
  input  logic  enable,
  input  logic  cmp,
  input  logic  pol,
  output gate_t gate_h,
  output gate_t gate_l
);

  logic         pol_q;
  logic         pol_change;
  logic         trip;
  gate_t        low_legs;
  blank_timer_t blank_timer;
  off_timer_t   off_timer;
  decay_t       mode;

  always_ff @(posedge clk) begin
    pol_q <= pol;
  end

  assign pol_change = pol != pol_q;

  // ====================================================================
  // Blanking and off time
  // ====================================================================

  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_timer <= '0;
    end else if (pol_change) begin
      blank_timer <= blank_timer_t'(`BLANK_TIME);  // Reversal spike would trip the comparator
    end else if (blank_timer != '0) begin
      blank_timer <= blank_timer - blank_timer_t'(1);
    end
  end

  // A trip counts only outside blanking and between off periods
  assign trip = cmp && (blank_timer == '0) && (off_timer == '0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      off_timer <= '0;
    end else if (trip) begin
      off_timer <= off_timer_t'(`OFF_TIME);
    end else if (off_timer != '0) begin
      off_timer <= off_timer - off_timer_t'(1);
    end
  end

  always_comb begin
    if (!enable) begin
      mode = coast;
    end else if (off_timer >= off_timer_t'(`FAST_DECAY_LIMIT)) begin
      mode = fast_decay;  // Early part of the off period
    end else if (off_timer != '0) begin
      mode = slow_decay;
    end else begin
      mode = drive;
    end
  end

  // ====================================================================
  // Leg encoding
  // ====================================================================

  // A set bit marks a leg pulled low, where h and l are both 1
  assign low_legs = pol ? 2'b10 : 2'b01;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      gate_h <= 2'b11;
      gate_l <= 2'b00;
    end else begin
      case (mode)
        drive: begin
          gate_h <= low_legs;
          gate_l <= low_legs;
        end
        fast_decay: begin
          gate_h <= ~low_legs;  // Bridge reversed against the coil current
          gate_l <= ~low_legs;
        end
        slow_decay: begin
          gate_h <= 2'b11;
          gate_l <= 2'b11;
        end
        default: begin
          gate_h <= 2'b11;  // Coast with every switch open
          gate_l <= 2'b00;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/cosine_table.sv
`timescale 1ns/1ps
`default_nettype none

module cosine_table
  import stepper_pkg::*;
(
  input  table_index_t index,
  output magnitude_t   magnitude
);

  // Entry i is round(255 * cos((i + 0.5) * pi / 128))
  // The half step offset keeps the folded quadrants symmetric
  localparam magnitude_t cos_rom [64] = '{
    8'd255, 8'd255, 8'd255, 8'd254, 8'd253, 8'd253, 8'd252, 8'd251,
    8'd249, 8'd248, 8'd247, 8'd245, 8'd243, 8'd241, 8'd239, 8'd237,
    8'd234, 8'd232, 8'd229, 8'd226, 8'd223, 8'd220, 8'd217, 8'd214,
    8'd210, 8'd207, 8'd203, 8'd199, 8'd195, 8'd191, 8'd187, 8'd183,
    8'd178, 8'd174, 8'd169, 8'd164, 8'd159, 8'd154, 8'd149, 8'd144,
    8'd139, 8'd134, 8'd128, 8'd123, 8'd117, 8'd112, 8'd106, 8'd100,
    8'd95,  8'd89,  8'd83,  8'd77,  8'd71,  8'd65,  8'd59,  8'd53,
    8'd47,  8'd41,  8'd34,  8'd28,  8'd22,  8'd16,  8'd9,   8'd3
  };

  assign magnitude = cos_rom[index];

endmodule

`default_nettype wire

// File: rtl/current_reference_dac.sv
`timescale 1ns/1ps
`default_nettype none

module current_reference_dac
  import stepper_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  magnitude_t mag_a,
  input  magnitude_t mag_b,
  output logic       ref_a,
  output logic       ref_b
);

  magnitude_t pwm_count;  // One ramp shared by both channels

  // Each output is high for mag counts out of every 256
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pwm_count <= '0;
      ref_a     <= 1'b0;
      ref_b     <= 1'b0;
    end else begin
      pwm_count <= pwm_count + magnitude_t'(1);
      ref_a     <= pwm_count < mag_a;
      ref_b     <= pwm_count < mag_b;
    end
  end

endmodule

`default_nettype wire

// File: rtl/microstepper_macros.svh
`ifndef MICROSTEPPER_MACROS_SVH
`define MICROSTEPPER_MACROS_SVH

// Chopper timing in clk cycles
`define OFF_TIME          810  // Whole off period after a comparator trip
`define FAST_DECAY_LIMIT  706  // Off timer values at or above this are fast decay
`define BLANK_TIME        27   // Comparator ignored this long after a polarity flip
`define CP_HALF_PERIOD    16

// Timer register widths
`define OFF_TIMER_W       10
`define BLANK_TIMER_W     8

`endif

// File: rtl/microstepper_top.sv
`timescale 1ns/1ps
`default_nettype none

module microstepper_top
  import stepper_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  logic       cmp_a,
  input  logic       cmp_b,
  output logic [3:0] s_h,  // High-side gates, active low
  output logic [3:0] s_l,
  output logic       ref_a,
  output logic       ref_b,
  output logic       chargepump_pin
);

  table_index_t mag_index_a;
  table_index_t mag_index_b;
  magnitude_t   mag_a;
  magnitude_t   mag_b;
  logic         pol_a;
  logic         pol_b;

  // ====================================================================
  // Motion side
  // ====================================================================

  step_sequencer seq_i (
    .clk         (clk),
    .resetn      (resetn),
    .step        (step),
    .dir         (dir),
    .mag_index_a (mag_index_a),
    .mag_index_b (mag_index_b),
    .pol_a       (pol_a),
    .pol_b       (pol_b)
  );

  cosine_table cos_a (
    .index     (mag_index_a),
    .magnitude (mag_a)
  );

  cosine_table cos_b (
    .index     (mag_index_b),
    .magnitude (mag_b)
  );

  current_reference_dac dac_i (
    .clk    (clk),
    .resetn (resetn),
    .mag_a  (mag_a),
    .mag_b  (mag_b),
    .ref_a  (ref_a),
    .ref_b  (ref_b)
  );

  // ====================================================================
  // Power stage
  // ====================================================================

  coil_chopper chop_a (
    .clk    (clk),
    .resetn (resetn),
    .enable (enable),
    .cmp    (cmp_a),
    .pol    (pol_a),
    .gate_h (s_h[1:0]),
    .gate_l (s_l[1:0])
  );

  coil_chopper chop_b (
    .clk    (clk),
    .resetn (resetn),
    .enable (enable),
    .cmp    (cmp_b),
    .pol    (pol_b),
    .gate_h (s_h[3:2]),
    .gate_l (s_l[3:2])
  );

  charge_pump cp_i (
    .clk    (clk),
    .resetn (resetn),
    .pump   (chargepump_pin)
  );

endmodule

`default_nettype wire

// File: rtl/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer
  import stepper_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  input  logic         step,
  input  logic         dir,
  output table_index_t mag_index_a,
  output table_index_t mag_index_b,
  output logic         pol_a,
  output logic         pol_b
);

  logic   step_meta;
  logic   step_sync;
  logic   step_prev;
  logic   dir_meta;
  logic   dir_sync;
  logic   step_rise;
  phase_t phase;
  phase_t phase_b;

  // Odd quadrants read the table backwards
  function automatic table_index_t fold_index(input phase_t p);
    return p[6] ? ~p[5:0] : p[5:0];
  endfunction

  // Positive current in quadrants 0 and 3
  function automatic logic fold_pol(input phase_t p);
    return p[7] == p[6];
  endfunction

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_meta <= 1'b0;
      step_sync <= 1'b0;
      step_prev <= 1'b0;
      dir_meta  <= 1'b0;
      dir_sync  <= 1'b0;
    end else begin
      step_meta <= step;
      step_sync <= step_meta;
      step_prev <= step_sync;
      dir_meta  <= dir;
      dir_sync  <= dir_meta;
    end
  end

  assign step_rise = step_sync & ~step_prev;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase <= '0;
    end else if (step_rise) begin
      phase <= dir_sync ? phase + phase_t'(1) : phase - phase_t'(1);  // Wraps at 256
    end
  end

  assign phase_b = phase + phase_t'(64);  // Coil B sits a quarter cycle ahead

  assign mag_index_a = fold_index(phase);
  assign mag_index_b = fold_index(phase_b);
  assign pol_a       = fold_pol(phase);
  assign pol_b       = fold_pol(phase_b);

endmodule

`default_nettype wire

// File: rtl/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Electrical phase with 256 microsteps per cycle
  typedef logic [7:0] phase_t;

  // Address into the quarter-wave cosine table
  typedef logic [5:0] table_index_t;

  // Coil current magnitude and PWM duty
  typedef logic [7:0] magnitude_t;

endpackage

`default_nettype wire
